// File: common/issue_pkg.sv
// issue slice shared types: widths, ALU opcodes and the bus structs between stages
`default_nettype none

package issue_pkg;

    ////////////////////
    // sizes
    ////////////////////

    localparam int xlen         = 32;
    localparam int tag_width    = 5;
    localparam int rs_size      = 4;
    localparam int rs_idx_width = $clog2(rs_size);
    // shift amount taken from the low bits of operand b
    localparam int shamt_width  = $clog2(xlen);

    ////////////////////
    // opcodes
    ////////////////////

    typedef enum logic [2:0] {
        add,
        sub,
        and_op,
        or_op,
        xor_op,
        sll,
        srl,
        slt
    } alu_op_t;

    ////////////////////
    // stage structs
    ////////////////////

    // value is valid once ready is set, else waits on tag
    typedef struct packed {
        logic [tag_width-1:0] tag;
        logic [xlen-1:0]      value;
        logic                 ready;
    } operand_t;

    typedef struct packed {
        logic                 valid;
        alu_op_t              op;
        logic [tag_width-1:0] dest_tag;
        operand_t             src_a;
        operand_t             src_b;
    } dispatch_t;

    typedef struct packed {
        logic                 busy;
        logic                 issued;
        alu_op_t              op;
        logic [tag_width-1:0] dest_tag;
        operand_t             src_a;
        operand_t             src_b;
    } rs_entry_t;

    // station to ALU, start is a one cycle strobe
    typedef struct packed {
        logic                 start;
        alu_op_t              op;
        logic [tag_width-1:0] dest_tag;
        logic [xlen-1:0]      a;
        logic [xlen-1:0]      b;
    } issue_t;

    typedef struct packed {
        logic                 valid;
        logic [tag_width-1:0] dest_tag;
        logic [xlen-1:0]      value;
    } alu_result_t;

    typedef struct packed {
        logic                 valid;
        logic [tag_width-1:0] tag;
        logic [xlen-1:0]      value;
    } cdb_t;

endpackage

`default_nettype wire

// File: reservation_station/reservation_station.sv
// reservation station: holds four ALU instructions, wakes operands from the CDB, issues
`default_nettype none
`timescale 1ns/1ps

module reservation_station import issue_pkg::*; (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       squash,
    input  dispatch_t                  dispatch,
    input  cdb_t                       cdb,
    input  logic [rs_size-1:0]         grant,
    output issue_t [rs_size-1:0]       issue,
    output logic                       full
);

    rs_entry_t [rs_size-1:0]   entries;
    rs_entry_t [rs_size-1:0]   entries_next;

    operand_t  [rs_size-1:0]   src_a_fwd;
    operand_t  [rs_size-1:0]   src_b_fwd;
    logic      [rs_size-1:0]   start;
    logic      [rs_size-1:0]   busy;
    logic      [rs_size-1:0]   free;
    logic [rs_idx_width-1:0]   slot;
    logic                      accept;

    // take the CDB value if this operand waits on the broadcast tag
    function automatic operand_t forward_operand(input operand_t opnd, input cdb_t bus);
        operand_t fwd;
        fwd = opnd;
        if (!opnd.ready && bus.valid && bus.tag == opnd.tag) begin
            fwd.value = bus.value;
            fwd.ready = 1'b1;
        end
        return fwd;
    endfunction

    ////////////////////
    // wake-up and issue
    ////////////////////

    always_comb begin
        for (int i = 0; i < rs_size; i++) begin
            src_a_fwd[i] = forward_operand(entries[i].src_a, cdb);
            src_b_fwd[i] = forward_operand(entries[i].src_b, cdb);
            busy[i]      = entries[i].busy;

            // first cycle with both operands complete, forwarding included
            start[i] = entries[i].busy && !entries[i].issued &&
                       src_a_fwd[i].ready && src_b_fwd[i].ready;

            issue[i].start    = start[i];
            issue[i].op       = entries[i].op;
            issue[i].dest_tag = entries[i].dest_tag;
            issue[i].a        = src_a_fwd[i].value;
            issue[i].b        = src_b_fwd[i].value;
        end
    end

    ////////////////////
    // allocation
    ////////////////////

    // a granted entry frees on the next edge, so it counts as free now
    assign free   = ~busy | grant;
    assign full   = (&busy) && !(|grant);
    assign accept = dispatch.valid && !full && !squash;

    // lowest free entry wins, scanning down so the last hit is the lowest
    always_comb begin
        slot = '0;
        for (int i = rs_size - 1; i >= 0; i--) begin
            if (free[i]) begin
                slot = rs_idx_width'(i);
            end
        end
    end

    ////////////////////
    // next entry state
    ////////////////////

    always_comb begin
        entries_next = entries;

        for (int i = 0; i < rs_size; i++) begin
            entries_next[i].src_a = src_a_fwd[i];
            entries_next[i].src_b = src_b_fwd[i];
            if (start[i]) begin
                entries_next[i].issued = 1'b1;
            end
            if (grant[i]) begin
                entries_next[i].busy   = 1'b0;
                entries_next[i].issued = 1'b0;
            end
        end

        // new instruction, operands may catch this cycle's broadcast
        if (accept) begin
            entries_next[slot].busy     = 1'b1;
            entries_next[slot].issued   = 1'b0;
            entries_next[slot].op       = dispatch.op;
            entries_next[slot].dest_tag = dispatch.dest_tag;
            entries_next[slot].src_a    = forward_operand(dispatch.src_a, cdb);
            entries_next[slot].src_b    = forward_operand(dispatch.src_b, cdb);
        end
    end

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            for (int i = 0; i < rs_size; i++) begin
                entries[i].busy   <= 1'b0;
                entries[i].issued <= 1'b0;
            end
        end else begin
            entries <= entries_next;
        end
    end

endmodule

`default_nettype wire

// File: logic/alu_unit.sv
// ALU for one station entry: registers the result and holds it until the CDB grant
`default_nettype none
`timescale 1ns/1ps

module alu_unit import issue_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        squash,
    input  issue_t      issue,
    input  logic        grant,
    output alu_result_t result
);

    logic [xlen-1:0] value_next;

    always_comb begin
        case (issue.op)
            add:     value_next = issue.a + issue.b;
            sub:     value_next = issue.a - issue.b;
            and_op:  value_next = issue.a & issue.b;
            or_op:   value_next = issue.a | issue.b;
            xor_op:  value_next = issue.a ^ issue.b;
            sll:     value_next = issue.a << issue.b[shamt_width-1:0];
            srl:     value_next = issue.a >> issue.b[shamt_width-1:0];
            // signed compare, zero extended flag
            slt:     value_next = {{(xlen-1){1'b0}}, $signed(issue.a) < $signed(issue.b)};
            default: value_next = '0;
        endcase
    end

    ////////////////////
    // result register
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            result.valid <= 1'b0;
        end else if (issue.start) begin
            result.valid    <= 1'b1;
            result.dest_tag <= issue.dest_tag;
            result.value    <= value_next;
        end else if (grant) begin
            // result went out on the CDB this cycle
            result.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: logic/cdb_arbiter.sv
// CDB arbiter: round-robin pick of one finished ALU result per cycle
`default_nettype none
`timescale 1ns/1ps

module cdb_arbiter import issue_pkg::*; (
    input  logic                          clock,
    input  logic                          reset,
    input  alu_result_t [rs_size-1:0]     results,
    output logic        [rs_size-1:0]     grant,
    output cdb_t                          cdb
);

    logic [rs_idx_width-1:0] ptr;
    logic [rs_idx_width-1:0] idx;
    logic [rs_idx_width-1:0] pick;
    logic                    found;

    // scan from the far end so the first valid at or after ptr wins
    always_comb begin
        pick  = ptr;
        found = 1'b0;
        idx   = ptr;
        for (int k = rs_size - 1; k >= 0; k--) begin
            idx = ptr + rs_idx_width'(k);
            if (results[idx].valid) begin
                pick  = idx;
                found = 1'b1;
            end
        end

        grant       = '0;
        grant[pick] = found;

        cdb.valid = found;
        cdb.tag   = results[pick].dest_tag;
        cdb.value = results[pick].value;
    end

    // next search starts just past the granted ALU
    always_ff @(posedge clock) begin
        if (reset) begin
            ptr <= '0;
        end else if (found) begin
            ptr <= pick + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/issue_core.sv
// issue core top: station, per-entry ALUs and CDB arbiter with the CDB fed back
`default_nettype none
`timescale 1ns/1ps

module issue_core import issue_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      squash,
    input  dispatch_t dispatch,
    output cdb_t      cdb,
    output logic      full
);

    issue_t      [rs_size-1:0] issue;
    alu_result_t [rs_size-1:0] results;
    logic        [rs_size-1:0] grant;

    reservation_station station_i (
        .clock    (clock),
        .reset    (reset),
        .squash   (squash),
        .dispatch (dispatch),
        .cdb      (cdb),
        .grant    (grant),
        .issue    (issue),
        .full     (full)
    );

    // one ALU per station entry
    for (genvar g = 0; g < rs_size; g++) begin : gen_alu
        alu_unit alu_i (
            .clock  (clock),
            .reset  (reset),
            .squash (squash),
            .issue  (issue[g]),
            .grant  (grant[g]),
            .result (results[g])
        );
    end

    cdb_arbiter arbiter_i (
        .clock   (clock),
        .reset   (reset),
        .results (results),
        .grant   (grant),
        .cdb     (cdb)
    );

endmodule

`default_nettype wire

// File: verification/issue_core_assert.sv
// issue core protocol checks: grant shape, CDB tags and behavior after squash and reset
`default_nettype none
`timescale 1ns/1ps

module issue_core_assert import issue_pkg::*; (
    input logic               clock,
    input logic               reset,
    input logic               squash,
    input logic [rs_size-1:0] grant,
    input cdb_t               cdb,
    input logic               full
);

    grant_onehot: assert property (@(posedge clock) disable iff (reset) $onehot0(grant))
        else $error("grant has more than one bit set");

    // tag zero is never a destination
    cdb_tag_nonzero: assert property (@(posedge clock) disable iff (reset)
        cdb.valid |-> (cdb.tag != '0))
        else $error("CDB valid with tag zero");

    squash_quiet: assert property (@(posedge clock) disable iff (reset) squash |=> !cdb.valid)
        else $error("CDB valid in the cycle after squash");

    reset_not_full: assert property (@(posedge clock) reset |=> !full)
        else $error("full high in the cycle after reset");

endmodule

bind issue_core issue_core_assert assert_i (
    .clock  (clock),
    .reset  (reset),
    .squash (squash),
    .grant  (grant),
    .cdb    (cdb),
    .full   (full)
);

`default_nettype wire

// File: verification/issue_core_tb.sv
// issue core testbench: dispatch stimulus, reference model and checks on the CDB and full flag
`default_nettype none
`timescale 1ns/1ps

module issue_core_tb import issue_pkg::*; ();

    // five tests of about 20 cycles each, with a wide margin
    localparam int cycle_limit = 400;

    logic      clock;
    logic      reset;
    logic      squash;
    dispatch_t dispatch;
    cdb_t      cdb;
    logic      full;

    logic [xlen-1:0]         expected [2**tag_width];
    logic [2**tag_width-1:0] outstanding = '0;
    int                      busy_count  = 0;
    int                      errors      = 0;
    int                      tests_done  = 0;
    int                      cycles      = 0;
    logic [31:0]             lcg_state;
    logic                    model_full;
    logic                    model_accept;
    bit                      run_ended;

    issue_core dut_i (
        .clock    (clock),
        .reset    (reset),
        .squash   (squash),
        .dispatch (dispatch),
        .cdb      (cdb),
        .full     (full)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    ////////////////////
    // reference model
    ////////////////////

    function automatic logic [xlen-1:0] ref_result(input alu_op_t op,
                                                    input logic [xlen-1:0] a,
                                                    input logic [xlen-1:0] b);
        logic signed [xlen-1:0] sa;
        logic signed [xlen-1:0] sb;
        sa = a;
        sb = b;
        case (op)
            add:     return a + b;
            sub:     return a + ~b + 32'd1;
            and_op:  return a & b;
            or_op:   return a | b;
            xor_op:  return a ^ b;
            sll:     return a << b[4:0];
            srl:     return a >> b[4:0];
            slt:     return (sa < sb) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    // a waiting operand takes its producer's predicted value
    function automatic logic [xlen-1:0] operand_value(input operand_t opnd);
        return opnd.ready ? opnd.value : expected[opnd.tag];
    endfunction

    assign model_full   = (busy_count == rs_size) && !cdb.valid;
    assign model_accept = dispatch.valid && !model_full && !squash;

    always @(posedge clock) begin
        if (reset || squash) begin
            outstanding <= '0;
            busy_count  <= 0;
        end else begin
            if (cdb.valid) begin
                outstanding[cdb.tag] <= 1'b0;
            end
            if (model_accept) begin
                outstanding[dispatch.dest_tag] <= 1'b1;
                expected[dispatch.dest_tag]    <= ref_result(dispatch.op,
                    operand_value(dispatch.src_a), operand_value(dispatch.src_b));
            end
            // a broadcast frees its entry on this edge
            busy_count <= busy_count + (model_accept ? 1 : 0) - (cdb.valid ? 1 : 0);
        end
    end

    cdb_value_check: assert property (@(posedge clock) disable iff (reset)
        cdb.valid |-> (cdb.value == expected[cdb.tag]))
        else begin
            errors++;
            $display("ERROR at %0t: tag %0d broadcast %h, expected %h", $time,
                     $sampled(cdb.tag), $sampled(cdb.value), expected[$sampled(cdb.tag)]);
        end

    cdb_tag_check: assert property (@(posedge clock) disable iff (reset)
        cdb.valid |-> outstanding[cdb.tag])
        else begin
            errors++;
            $display("ERROR at %0t: tag %0d broadcast but not outstanding", $time,
                     $sampled(cdb.tag));
        end

    full_check: assert property (@(posedge clock) disable iff (reset) full == model_full)
        else begin
            errors++;
            $display("ERROR at %0t: full is %b, model expects %b", $time,
                     $sampled(full), $sampled(model_full));
        end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            run_ended = 1'b1;
            $display("run timed out after %0d cycles with tags still pending", cycles);
            $display("tests failed");
            $finish;
        end
    end

    // a bound assertion can stop the run early
    final begin
        if (!run_ended) begin
            $display("run stopped before all tests finished");
            $display("tests failed");
        end
    end

    ////////////////////
    // stimulus
    ////////////////////

    function automatic logic [31:0] random_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic operand_t ready_operand(input logic [xlen-1:0] value);
        return '{tag: '0, value: value, ready: 1'b1};
    endfunction

    function automatic operand_t waiting_operand(input logic [tag_width-1:0] tag);
        return '{tag: tag, value: '0, ready: 1'b0};
    endfunction

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic send(input alu_op_t op, input logic [tag_width-1:0] dest,
                        input operand_t a, input operand_t b);
        dispatch.valid    = 1'b1;
        dispatch.op       = op;
        dispatch.dest_tag = dest;
        dispatch.src_a    = a;
        dispatch.src_b    = b;
        next_cycle();
        dispatch = '0;
    endtask

    // until every tag has broadcast and every entry is free
    task automatic wait_idle();
        while (outstanding != '0 || busy_count != 0) begin
            next_cycle();
        end
    endtask

    task automatic finish_test(input string name);
        tests_done++;
        $display("test %0d (%s) finished, errors so far %0d", tests_done, name, errors);
    endtask

    initial begin
        reset     = 1'b1;
        squash    = 1'b0;
        dispatch  = '0;
        lcg_state = 32'd79019;
        run_ended = 1'b0;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;
        next_cycle();

        for (int i = 0; i < 8; i++) begin
            send(alu_op_t'(i[2:0]), tag_width'(i + 1), ready_operand(random_word()),
                 ready_operand(random_word()));
        end
        wait_idle();
        finish_test("every opcode, ready operands");

        // gap so tag 11 meets tag 10 on the CDB at dispatch
        send(add, 5'd10, ready_operand(random_word()), ready_operand(random_word()));
        next_cycle();
        send(sub, 5'd11, waiting_operand(5'd10), ready_operand(random_word()));
        send(sll, 5'd12, waiting_operand(5'd11), ready_operand(random_word()));
        wait_idle();
        finish_test("dependency chain");

        send(or_op, 5'd13, ready_operand(random_word()), ready_operand(random_word()));
        send(and_op, 5'd14, ready_operand(random_word()), ready_operand(random_word()));
        send(slt, 5'd15, ready_operand(random_word()), ready_operand(random_word()));
        send(srl, 5'd16, ready_operand(random_word()), ready_operand(random_word()));
        wait_idle();
        finish_test("four ready instructions");

        // tag 31 is never produced, fifth dispatch meets a full station
        for (int i = 0; i < 5; i++) begin
            send(xor_op, tag_width'(17 + i), waiting_operand(5'd31),
                 ready_operand(random_word()));
        end
        repeat (4) next_cycle();
        finish_test("full station drops dispatch");

        squash = 1'b1;
        next_cycle();
        squash = 1'b0;
        repeat (3) next_cycle();
        // squash lands while this result enters its ALU
        send(add, 5'd22, ready_operand(random_word()), ready_operand(random_word()));
        squash = 1'b1;
        next_cycle();
        squash = 1'b0;
        // producing tag 31 would wake any entry left behind
        send(add, 5'd31, ready_operand(random_word()), ready_operand(random_word()));
        wait_idle();
        finish_test("squash and fresh instruction");

        run_ended = 1'b1;
        $display("tests run %0d, errors %0d", tests_done, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
common/issue_pkg.sv
reservation_station/reservation_station.sv
logic/alu_unit.sv
logic/cdb_arbiter.sv
logic/issue_core.sv
verification/issue_core_assert.sv
verification/issue_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the issue core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f compile.f \
    --top-module issue_core_tb \
    -o issue_core_sim

./obj_dir/issue_core_sim 2>&1 | tee sim.log

if grep -q "all tests passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
